// File: common/arbiter_pkg.sv
package arbiter_pkg;

	// Client beats popped for one write burst
	localparam int BURST_BEATS = 4;

	// Cycles from a client rd_en to valid client data
	localparam int CLIENT_RD_LATENCY = 2;

	// Client FIFO fill level widths
	localparam int DATA_SIZE_WIDTH = 10;
	localparam int ADDR_SIZE_WIDTH = 8;

	// Width of the free-slot count reported by the internal queues
	localparam int QUEUE_LEVEL_WIDTH = 8;

	// Counts beats within a burst, 0 to BURST_BEATS
	typedef logic [2:0] burst_count_t;

endpackage

// File: common/mig_app_pkg.sv
package mig_app_pkg;

	// Memory controller application bus address width
	localparam int APP_ADDR_WIDTH = 29;

	typedef logic [APP_ADDR_WIDTH-1:0] app_addr_t;

	// app_cmd encoding
	typedef enum logic [2:0] {
		APP_CMD_WRITE = 3'd0,
		APP_CMD_READ  = 3'd1
	} app_cmd_t;

	// One queued command, 32 bits
	typedef struct packed {
		app_cmd_t  cmd;
		app_addr_t addr;
	} cmd_entry_t;

endpackage

// File: source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
	import arbiter_pkg::*;
#(
	parameter type entry_t = logic [31:0],
	parameter int  DEPTH   = 16
)(
	input  logic                         clk_ram,
	input  logic                         trig_rst_arbiter_2x,
	input  logic                         push,
	input  entry_t                       push_entry,
	input  logic                         pop,
	output entry_t                       head,
	output logic                         not_empty,
	output logic [QUEUE_LEVEL_WIDTH-1:0] free
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	entry_t                mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;

	// Wrap explicitly so DEPTH need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Storage
	always_ff @(posedge clk_ram) begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	// Pointers and occupancy
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// First word fall through, head is live one cycle after push
	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign free      = QUEUE_LEVEL_WIDTH'(DEPTH - count);

	// Producer must respect free, consumer must respect not_empty
	assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		push |-> (count != COUNT_BITS'(DEPTH)))
		else $error("sync_fifo: push while full");
	assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		pop |-> not_empty)
		else $error("sync_fifo: pop while empty");

endmodule

// File: arbiter/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter
	import arbiter_pkg::*;
#(
	parameter int NUM_PORTS = 3
)(
	input  logic                                      clk_ram,
	input  logic                                      trig_rst_arbiter_2x,
	input  logic [NUM_PORTS-1:0][DATA_SIZE_WIDTH-1:0] beat_size,
	input  logic [NUM_PORTS-1:0][ADDR_SIZE_WIDTH-1:0] addr_size,
	input  logic [QUEUE_LEVEL_WIDTH-1:0]              data_free,
	input  logic [QUEUE_LEVEL_WIDTH-1:0]              cmd_free,
	output logic [NUM_PORTS-1:0]                      beat_rd_en,
	output logic [NUM_PORTS-1:0]                      addr_rd_en,
	output logic [$clog2(NUM_PORTS)-1:0]              src_port,
	output logic                                      beat_valid,
	output logic                                      addr_valid
);

	localparam int PORT_BITS = $clog2(NUM_PORTS);
	localparam int LAST_PORT = NUM_PORTS - 1;

	// One word of the previous burst may still be in flight
	localparam int MIN_DATA_FREE = 3;
	localparam int MIN_CMD_FREE  = 2;

	logic [NUM_PORTS-1:0]         port_ready;
	logic [PORT_BITS-1:0]         rr_ptr;
	logic [PORT_BITS-1:0]         grant;
	logic [PORT_BITS-1:0]         cur_port;
	logic [PORT_BITS-1:0]         pop_port;
	burst_count_t                 beats_left;
	logic                         gap;
	logic                         room;
	logic                         start;
	logic [CLIENT_RD_LATENCY-1:0] beat_pipe;
	logic [CLIENT_RD_LATENCY-1:0] addr_pipe;
	logic [PORT_BITS-1:0]         port_pipe [CLIENT_RD_LATENCY];

	//////////////////////////////////////////////////////////////////////
	// Port selection

	// Pods need a full burst plus an address, readback only an address
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (i == LAST_PORT)
				port_ready[i] = (addr_size[i] != '0);
			else
				port_ready[i] = (beat_size[i] >= BURST_BEATS) && (addr_size[i] != '0);
		end
	end

	// Round robin winner first, else lowest numbered ready port
	always_comb begin
		grant = rr_ptr;
		if (!port_ready[rr_ptr]) begin
			for (int i = NUM_PORTS - 1; i >= 0; i--) begin
				if (port_ready[i])
					grant = PORT_BITS'(i);
			end
		end
	end

	assign room  = (data_free >= MIN_DATA_FREE) && (cmd_free >= MIN_CMD_FREE);
	assign start = !gap && (beats_left == '0) && room && (|port_ready);

	// Address and first beat go in the start cycle, rest follow back to back
	always_comb begin
		beat_rd_en = '0;
		addr_rd_en = '0;
		if (start) begin
			addr_rd_en[grant] = 1'b1;
			if (grant != LAST_PORT)
				beat_rd_en[grant] = 1'b1;
		end else if (beats_left != '0) begin
			beat_rd_en[cur_port] = 1'b1;
		end
	end

	assign pop_port = start ? grant : cur_port;

	//////////////////////////////////////////////////////////////////////
	// Burst sequencing

	// Gap comes out of reset set so no pop lands in the reset cycle
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			rr_ptr     <= '0;
			beats_left <= '0;
			gap        <= 1'b1;
		end else if (start) begin
			rr_ptr <= (grant == LAST_PORT) ? '0 : PORT_BITS'(grant + 1'b1);
			if (grant == LAST_PORT) begin
				// Readback is address only
				beats_left <= '0;
				gap        <= 1'b1;
			end else begin
				beats_left <= burst_count_t'(BURST_BEATS - 1);
				gap        <= 1'b0;
			end
		end else if (beats_left != '0) begin
			beats_left <= beats_left - 1'b1;
			gap        <= (beats_left == burst_count_t'(1));
		end else begin
			gap <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Align valid flags and source with client read latency

	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			beat_pipe <= '0;
			addr_pipe <= '0;
		end else begin
			beat_pipe[0] <= |beat_rd_en;
			addr_pipe[0] <= |addr_rd_en;
			for (int i = 1; i < CLIENT_RD_LATENCY; i++) begin
				beat_pipe[i] <= beat_pipe[i-1];
				addr_pipe[i] <= addr_pipe[i-1];
			end
		end
	end

	// Port tag travels with each pop so bursts can overlap in flight
	always_ff @(posedge clk_ram) begin
		if (start)
			cur_port <= grant;
		port_pipe[0] <= pop_port;
		for (int i = 1; i < CLIENT_RD_LATENCY; i++)
			port_pipe[i] <= port_pipe[i-1];
	end

	assign beat_valid = beat_pipe[CLIENT_RD_LATENCY-1];
	assign addr_valid = addr_pipe[CLIENT_RD_LATENCY-1];
	assign src_port   = port_pipe[CLIENT_RD_LATENCY-1];

	// Beat data from two clients would collide on the shared mux
	assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		$onehot0(beat_rd_en))
		else $error("port_arbiter: more than one beat rd_en high");

endmodule

// File: arbiter/burst_packer.sv
`timescale 1ns/1ps

module burst_packer
	import mig_app_pkg::*;
#(
	parameter int NUM_PORTS  = 3,
	parameter int BEAT_WIDTH = 128
)(
	input  logic                         clk_ram,
	input  logic                         trig_rst_arbiter_2x,
	input  logic                         beat_valid,
	input  logic                         addr_valid,
	input  logic [$clog2(NUM_PORTS)-1:0] src_port,
	input  logic [BEAT_WIDTH-1:0]        beat,
	input  app_addr_t                    addr,
	output logic                         cmd_push,
	output cmd_entry_t                   cmd_entry,
	output logic                         data_push,
	output logic [2*BEAT_WIDTH-1:0]      data_word
);

	localparam int LAST_PORT = NUM_PORTS - 1;

	// Low when the next beat starts a new word
	logic                  beat_phase;
	logic [BEAT_WIDTH-1:0] upper_beat;

	//////////////////////////////////////////////////////////////////////
	// Command side

	// Last port is readback, everyone else writes
	always_ff @(posedge clk_ram) begin
		if (addr_valid) begin
			cmd_entry.cmd  <= (src_port == LAST_PORT) ? APP_CMD_READ : APP_CMD_WRITE;
			cmd_entry.addr <= addr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data side

	// Earlier beat of a pair lands in the upper half
	always_ff @(posedge clk_ram) begin
		if (beat_valid) begin
			if (!beat_phase)
				upper_beat <= beat;
			else
				data_word <= {upper_beat, beat};
		end
	end

	// Push strobes and pairing phase
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			cmd_push   <= 1'b0;
			data_push  <= 1'b0;
			beat_phase <= 1'b0;
		end else begin
			cmd_push  <= addr_valid;
			data_push <= beat_valid && beat_phase;
			if (beat_valid)
				beat_phase <= !beat_phase;
		end
	end

endmodule

// File: source/mig_issuer.sv
`timescale 1ns/1ps

module mig_issuer
	import mig_app_pkg::*;
#(
	parameter int BEAT_WIDTH = 128
)(
	input  logic                      clk_ram,
	input  logic                      trig_rst_arbiter_2x,
	input  cmd_entry_t                cmd_head,
	input  logic                      cmd_not_empty,
	input  logic [2*BEAT_WIDTH-1:0]   data_head,
	input  logic                      data_not_empty,
	input  logic                      app_rdy,
	input  logic                      app_wdf_rdy,
	output logic                      cmd_pop,
	output logic                      data_pop,
	output app_addr_t                 app_addr,
	output app_cmd_t                  app_cmd,
	output logic                      app_en,
	output logic [2*BEAT_WIDTH-1:0]   app_wdf_data,
	output logic                      app_wdf_end,
	output logic [2*BEAT_WIDTH/8-1:0] app_wdf_mask,
	output logic                      app_wdf_wren
);

	logic cmd_load;
	logic data_load;
	logic wdf_accept;
	// Count of accepted words, mod 2
	logic word_phase;

	//////////////////////////////////////////////////////////////////////
	// Command channel

	// Output slot free or draining this cycle
	assign cmd_load = !app_en || app_rdy;
	assign cmd_pop  = cmd_load && cmd_not_empty;

	always_ff @(posedge clk_ram) begin
		if (cmd_pop) begin
			app_cmd  <= cmd_head.cmd;
			app_addr <= cmd_head.addr;
		end
	end

	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x)
			app_en <= 1'b0;
		else if (cmd_load)
			app_en <= cmd_not_empty;
	end

	//////////////////////////////////////////////////////////////////////
	// Write data channel

	assign wdf_accept = app_wdf_wren && app_wdf_rdy;
	assign data_load  = !app_wdf_wren || app_wdf_rdy;
	assign data_pop   = data_load && data_not_empty;

	always_ff @(posedge clk_ram) begin
		if (data_pop)
			app_wdf_data <= data_head;
	end

	// A loaded word is the second of its burst when one word is already out
	always_ff @(posedge clk_ram) begin
		if (trig_rst_arbiter_2x) begin
			app_wdf_wren <= 1'b0;
			app_wdf_end  <= 1'b0;
			word_phase   <= 1'b0;
		end else begin
			if (data_load) begin
				app_wdf_wren <= data_not_empty;
				app_wdf_end  <= data_not_empty && (word_phase ^ wdf_accept);
			end
			if (wdf_accept)
				word_phase <= !word_phase;
		end
	end

	// Nothing masked
	assign app_wdf_mask = '0;

	// Controller requires command and address held until accepted
	assert property (@(posedge clk_ram) disable iff (trig_rst_arbiter_2x)
		(app_en && !app_rdy) |=> (app_en && $stable(app_addr) && $stable(app_cmd)))
		else $error("mig_issuer: command changed before app_rdy");

endmodule

// File: source/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter
	import arbiter_pkg::*;
	import mig_app_pkg::*;
#(
	parameter int BEAT_WIDTH = 128,
	parameter int FIFO_DEPTH = 32
)(
	input  logic                        clk_ram,
	input  logic                        trig_rst_arbiter_2x,

	// Capture pod 0
	output logic                        la0_ram_data_rd_en,
	input  logic [BEAT_WIDTH-1:0]       la0_ram_data_rd_data,
	input  logic [DATA_SIZE_WIDTH-1:0]  la0_ram_data_rd_size,
	output logic                        la0_ram_addr_rd_en,
	input  app_addr_t                   la0_ram_addr_rd_data,
	input  logic [ADDR_SIZE_WIDTH-1:0]  la0_ram_addr_rd_size,

	// Capture pod 1
	output logic                        la1_ram_data_rd_en,
	input  logic [BEAT_WIDTH-1:0]       la1_ram_data_rd_data,
	input  logic [DATA_SIZE_WIDTH-1:0]  la1_ram_data_rd_size,
	output logic                        la1_ram_addr_rd_en,
	input  app_addr_t                   la1_ram_addr_rd_data,
	input  logic [ADDR_SIZE_WIDTH-1:0]  la1_ram_addr_rd_size,

	// Readback, addresses only
	output logic                        la_readback_ram_addr_rd_en,
	input  app_addr_t                   la_readback_ram_addr_rd_data,
	input  logic [ADDR_SIZE_WIDTH-1:0]  la_readback_ram_addr_rd_size,

	// Memory controller application bus
	output app_addr_t                   app_addr,
	output app_cmd_t                    app_cmd,
	output logic                        app_en,
	input  logic                        app_rdy,
	output logic [2*BEAT_WIDTH-1:0]     app_wdf_data,
	output logic                        app_wdf_end,
	output logic [2*BEAT_WIDTH/8-1:0]   app_wdf_mask,
	output logic                        app_wdf_wren,
	input  logic                        app_wdf_rdy
);

	// Port 2 is the read-only port
	localparam int NUM_PORTS  = 3;
	localparam int PORT_BITS  = $clog2(NUM_PORTS);
	localparam int WORD_WIDTH = 2 * BEAT_WIDTH;
	localparam int CMD_DEPTH  = FIFO_DEPTH / 2;

	typedef logic [WORD_WIDTH-1:0] data_word_t;

	logic [NUM_PORTS-1:0]                      beat_rd_en;
	logic [NUM_PORTS-1:0]                      addr_rd_en;
	logic [NUM_PORTS-1:0][DATA_SIZE_WIDTH-1:0] beat_size;
	logic [NUM_PORTS-1:0][ADDR_SIZE_WIDTH-1:0] addr_size;
	logic [NUM_PORTS-1:0][BEAT_WIDTH-1:0]      beat_data;
	app_addr_t [NUM_PORTS-1:0]                 addr_data;

	logic [PORT_BITS-1:0]         src_port;
	logic                         beat_valid;
	logic                         addr_valid;
	logic [BEAT_WIDTH-1:0]        beat_muxed;
	app_addr_t                    addr_muxed;

	logic                         cmd_push;
	cmd_entry_t                   cmd_entry;
	logic                         data_push;
	data_word_t                   data_word;
	logic [QUEUE_LEVEL_WIDTH-1:0] cmd_free;
	logic [QUEUE_LEVEL_WIDTH-1:0] data_free;
	cmd_entry_t                   cmd_head;
	logic                         cmd_not_empty;
	logic                         cmd_pop;
	data_word_t                   data_head;
	logic                         data_not_empty;
	logic                         data_pop;

	//////////////////////////////////////////////////////////////////////
	// Named client ports to numbered vectors

	assign la0_ram_data_rd_en         = beat_rd_en[0];
	assign la1_ram_data_rd_en         = beat_rd_en[1];
	assign la0_ram_addr_rd_en         = addr_rd_en[0];
	assign la1_ram_addr_rd_en         = addr_rd_en[1];
	assign la_readback_ram_addr_rd_en = addr_rd_en[2];

	// Readback has no beat FIFO, tie it off empty
	assign beat_size = {DATA_SIZE_WIDTH'(0), la1_ram_data_rd_size, la0_ram_data_rd_size};
	assign beat_data = {BEAT_WIDTH'(0), la1_ram_data_rd_data, la0_ram_data_rd_data};
	assign addr_size = {la_readback_ram_addr_rd_size, la1_ram_addr_rd_size,
		la0_ram_addr_rd_size};
	assign addr_data = {la_readback_ram_addr_rd_data, la1_ram_addr_rd_data,
		la0_ram_addr_rd_data};

	// src_port already lines up with client read latency
	assign beat_muxed = beat_data[src_port];
	assign addr_muxed = addr_data[src_port];

	//////////////////////////////////////////////////////////////////////
	// Arbitration and packing

	port_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) port_arbiter_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.beat_size(beat_size),
		.addr_size(addr_size),
		.data_free(data_free),
		.cmd_free(cmd_free),
		.beat_rd_en(beat_rd_en),
		.addr_rd_en(addr_rd_en),
		.src_port(src_port),
		.beat_valid(beat_valid),
		.addr_valid(addr_valid)
	);

	burst_packer #(
		.NUM_PORTS(NUM_PORTS),
		.BEAT_WIDTH(BEAT_WIDTH)
	) burst_packer_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.beat_valid(beat_valid),
		.addr_valid(addr_valid),
		.src_port(src_port),
		.beat(beat_muxed),
		.addr(addr_muxed),
		.cmd_push(cmd_push),
		.cmd_entry(cmd_entry),
		.data_push(data_push),
		.data_word(data_word)
	);

	//////////////////////////////////////////////////////////////////////
	// Command and data queues

	// Two words per command, so half the depth
	sync_fifo #(
		.entry_t(cmd_entry_t),
		.DEPTH(CMD_DEPTH)
	) cmd_fifo_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.push(cmd_push),
		.push_entry(cmd_entry),
		.pop(cmd_pop),
		.head(cmd_head),
		.not_empty(cmd_not_empty),
		.free(cmd_free)
	);

	sync_fifo #(
		.entry_t(data_word_t),
		.DEPTH(FIFO_DEPTH)
	) data_fifo_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.push(data_push),
		.push_entry(data_word),
		.pop(data_pop),
		.head(data_head),
		.not_empty(data_not_empty),
		.free(data_free)
	);

	// Issue onto the controller bus
	mig_issuer #(
		.BEAT_WIDTH(BEAT_WIDTH)
	) mig_issuer_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.cmd_head(cmd_head),
		.cmd_not_empty(cmd_not_empty),
		.data_head(data_head),
		.data_not_empty(data_not_empty),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.cmd_pop(cmd_pop),
		.data_pop(data_pop),
		.app_addr(app_addr),
		.app_cmd(app_cmd),
		.app_en(app_en),
		.app_wdf_data(app_wdf_data),
		.app_wdf_end(app_wdf_end),
		.app_wdf_mask(app_wdf_mask),
		.app_wdf_wren(app_wdf_wren)
	);

endmodule

// File: verif/memory_arbiter_tb.sv
`timescale 1ns/1ps

module memory_arbiter_tb
	import arbiter_pkg::*;
	import mig_app_pkg::*;
();

	localparam int BEAT_WIDTH   = 128;
	localparam int WORD_WIDTH   = 2 * BEAT_WIDTH;
	localparam int MAX_BURSTS   = 8;
	localparam int WAIT_LIMIT   = 4000;
	localparam int QUIET_CYCLES = 24;

	// DUT side
	logic                       clk_ram;
	logic                       trig_rst_arbiter_2x;
	logic [1:0]                 data_rd_en;
	logic [BEAT_WIDTH-1:0]      data_rd_data [2];
	logic [DATA_SIZE_WIDTH-1:0] data_rd_size [2];
	logic [2:0]                 addr_rd_en;
	app_addr_t                  addr_rd_data [3];
	logic [ADDR_SIZE_WIDTH-1:0] addr_rd_size [3];
	app_addr_t                  app_addr;
	app_cmd_t                   app_cmd;
	logic                       app_en;
	logic                       app_rdy;
	logic [WORD_WIDTH-1:0]      app_wdf_data;
	logic                       app_wdf_end;
	logic [WORD_WIDTH/8-1:0]    app_wdf_mask;
	logic                       app_wdf_wren;
	logic                       app_wdf_rdy;

	// Client FIFO models, port 2 holds addresses only
	logic [BEAT_WIDTH-1:0] beat_mem [2][4*MAX_BURSTS];
	app_addr_t             addr_mem [3][MAX_BURSTS];
	int                    n_bursts [3];
	int                    beat_rd [2];
	int                    addr_rd [3];
	logic [BEAT_WIDTH-1:0] beat_pend [2];
	logic [BEAT_WIDTH-1:0] beat_stage [2];
	app_addr_t             addr_pend [3];
	app_addr_t             addr_stage [3];

	// Scoreboard
	int                    cmd_seen [3];
	int                    first_ports [3];
	int                    wr_q [$];
	logic [WORD_WIDTH-1:0] word_q [$];
	logic                  end_q [$];
	int                    cmd_total;
	int                    word_total;
	int                    test_errors;
	int                    errors;
	int                    tests;
	int                    failed_tests;
	string                 test_name;
	logic [15:0]           lfsr;
	logic                  back_pressure;
	logic                  in_reset;
	logic                  quiet;

	memory_arbiter #(
		.BEAT_WIDTH(BEAT_WIDTH),
		.FIFO_DEPTH(32)
	) memory_arbiter_inst (
		.clk_ram(clk_ram),
		.trig_rst_arbiter_2x(trig_rst_arbiter_2x),
		.la0_ram_data_rd_en(data_rd_en[0]),
		.la0_ram_data_rd_data(data_rd_data[0]),
		.la0_ram_data_rd_size(data_rd_size[0]),
		.la0_ram_addr_rd_en(addr_rd_en[0]),
		.la0_ram_addr_rd_data(addr_rd_data[0]),
		.la0_ram_addr_rd_size(addr_rd_size[0]),
		.la1_ram_data_rd_en(data_rd_en[1]),
		.la1_ram_data_rd_data(data_rd_data[1]),
		.la1_ram_data_rd_size(data_rd_size[1]),
		.la1_ram_addr_rd_en(addr_rd_en[1]),
		.la1_ram_addr_rd_data(addr_rd_data[1]),
		.la1_ram_addr_rd_size(addr_rd_size[1]),
		.la_readback_ram_addr_rd_en(addr_rd_en[2]),
		.la_readback_ram_addr_rd_data(addr_rd_data[2]),
		.la_readback_ram_addr_rd_size(addr_rd_size[2]),
		.app_addr(app_addr),
		.app_cmd(app_cmd),
		.app_en(app_en),
		.app_rdy(app_rdy),
		.app_wdf_data(app_wdf_data),
		.app_wdf_end(app_wdf_end),
		.app_wdf_mask(app_wdf_mask),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_rdy(app_wdf_rdy)
	);

	// 100 ns clock
	initial begin
		clk_ram = 1'b0;
		forever #50 clk_ram = ~clk_ram;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [BEAT_WIDTH-1:0] random_beat();
		logic [BEAT_WIDTH-1:0] b;
		for (int i = 0; i < BEAT_WIDTH; i++)
			b[i] = lfsr_bit();
		return b;
	endfunction

	task automatic report_mismatch(input string what, input logic [WORD_WIDTH-1:0] expected,
		input logic [WORD_WIDTH-1:0] actual);
		$display("mismatch %0s %0s: expected %0h actual %0h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%0s: %0s", test_name, what);
		test_errors++;
	endtask

	// Fill the client models, addresses step by 8 from the base
	task automatic load_clients(input int b0, input int b1, input int b2,
		input app_addr_t a0, input app_addr_t a1, input app_addr_t a2);
		app_addr_t base [3];
		n_bursts = '{b0, b1, b2};
		base = '{a0, a1, a2};
		for (int p = 0; p < 3; p++) begin
			addr_rd[p] = 0;
			cmd_seen[p] = 0;
			first_ports[p] = -1;
			for (int k = 0; k < MAX_BURSTS; k++)
				addr_mem[p][k] = base[p] + app_addr_t'(8 * k);
		end
		for (int p = 0; p < 2; p++) begin
			beat_rd[p] = 0;
			for (int i = 0; i < 4 * MAX_BURSTS; i++)
				beat_mem[p][i] = random_beat();
		end
		wr_q.delete();
		word_q.delete();
		end_q.delete();
		cmd_total = 0;
		word_total = 0;
		test_errors = 0;
	endtask

	// Match write commands to word pairs in issue order
	task automatic check_word_pairs();
		int tag;
		int beat;
		int port;
		logic [WORD_WIDTH-1:0] expected;
		while (wr_q.size() > 0 && word_q.size() >= 2) begin
			tag = wr_q.pop_front();
			port = tag / MAX_BURSTS;
			beat = 4 * (tag % MAX_BURSTS);
			for (int w = 0; w < 2; w++) begin
				// Earlier beat in the upper half
				expected = {beat_mem[port][beat + 2*w], beat_mem[port][beat + 2*w + 1]};
				assert (word_q[0] == expected)
				else report_mismatch("app_wdf_data", expected, word_q[0]);
				assert (end_q[0] == (w == 1))
				else report_mismatch("app_wdf_end", WORD_WIDTH'(w == 1), WORD_WIDTH'(end_q[0]));
				void'(word_q.pop_front());
				void'(end_q.pop_front());
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Per cycle sampling and driving

	// Sampled at the falling edge, what the next rising edge sees
	task automatic sample_outputs();
		int port;
		int idx;
		app_cmd_t exp_cmd;
		if (in_reset)
			return;
		if (quiet) begin
			assert (!app_en && !app_wdf_wren && data_rd_en == '0 && addr_rd_en == '0)
			else report_failure("activity on the client or app bus while idle");
		end
		// Client pops
		for (int p = 0; p < 3; p++) begin
			if (addr_rd_en[p]) begin
				assert (addr_rd[p] < n_bursts[p])
				else report_failure("address popped from an empty client FIFO");
				if (addr_rd[p] < n_bursts[p])
					addr_pend[p] = addr_mem[p][addr_rd[p]];
				addr_rd[p]++;
			end
		end
		for (int p = 0; p < 2; p++) begin
			if (data_rd_en[p]) begin
				assert (beat_rd[p] < 4 * n_bursts[p])
				else report_failure("beat popped from an empty client FIFO");
				if (beat_rd[p] < 4 * n_bursts[p])
					beat_pend[p] = beat_mem[p][beat_rd[p]];
				beat_rd[p]++;
			end
		end
		// Accepted command, port sits in the top address bits
		if (app_en && app_rdy) begin
			port = int'(app_addr[APP_ADDR_WIDTH-1 -: 2]);
			assert (port < 3 && cmd_seen[port] < n_bursts[port])
			else report_failure("command issued with no matching queued burst");
			if (port < 3 && cmd_seen[port] < n_bursts[port]) begin
				idx = cmd_seen[port];
				exp_cmd = (port == 2) ? APP_CMD_READ : APP_CMD_WRITE;
				assert (app_addr == addr_mem[port][idx])
				else report_mismatch("app_addr", addr_mem[port][idx], app_addr);
				assert (app_cmd == exp_cmd)
				else report_mismatch("app_cmd", exp_cmd, app_cmd);
				if (cmd_total < 3)
					first_ports[cmd_total] = port;
				if (port != 2)
					wr_q.push_back(port * MAX_BURSTS + idx);
				cmd_seen[port]++;
			end
			cmd_total++;
		end
		// Accepted word
		if (app_wdf_wren && app_wdf_rdy) begin
			assert (app_wdf_mask == '0)
			else report_mismatch("app_wdf_mask", '0, WORD_WIDTH'(app_wdf_mask));
			word_q.push_back(app_wdf_data);
			end_q.push_back(app_wdf_end);
			word_total++;
		end
		check_word_pairs();
	endtask

	// Two stage read pipe matches CLIENT_RD_LATENCY, size drops after the pop
	task automatic drive_inputs();
		for (int p = 0; p < 3; p++) begin
			addr_rd_data[p] = addr_stage[p];
			addr_stage[p] = addr_pend[p];
			addr_rd_size[p] = ADDR_SIZE_WIDTH'(n_bursts[p] - addr_rd[p]);
		end
		for (int p = 0; p < 2; p++) begin
			data_rd_data[p] = beat_stage[p];
			beat_stage[p] = beat_pend[p];
			data_rd_size[p] = DATA_SIZE_WIDTH'(4 * n_bursts[p] - beat_rd[p]);
		end
		app_rdy = back_pressure ? lfsr_bit() : 1'b1;
		app_wdf_rdy = back_pressure ? lfsr_bit() : 1'b1;
	endtask

	task automatic run_cycle();
		@(negedge clk_ram);
		sample_outputs();
		@(posedge clk_ram);
		#5;
		drive_inputs();
	endtask

	//////////////////////////////////////////////////////////////////////
	// One test: reset, drain, idle window, totals

	task automatic run_test(input int exp_cmds, input int exp_words);
		int waited;
		in_reset = 1'b1;
		quiet = 1'b0;
		trig_rst_arbiter_2x = 1'b1;
		for (int i = 0; i < 8; i++)
			run_cycle();
		trig_rst_arbiter_2x = 1'b0;
		in_reset = 1'b0;
		waited = 0;
		while ((cmd_total < exp_cmds || word_total < exp_words) && waited < WAIT_LIMIT) begin
			run_cycle();
			waited++;
		end
		assert (cmd_total >= exp_cmds && word_total >= exp_words)
		else report_failure("timed out waiting for commands and data words");
		// Everything issued, bus and clients must now stay quiet
		quiet = 1'b1;
		for (int i = 0; i < QUIET_CYCLES; i++)
			run_cycle();
		quiet = 1'b0;
		for (int p = 0; p < 3; p++) begin
			assert (cmd_seen[p] == n_bursts[p])
			else report_mismatch("commands per port", n_bursts[p], cmd_seen[p]);
		end
		assert (cmd_total == exp_cmds)
		else report_mismatch("command count", exp_cmds, cmd_total);
		assert (word_total == exp_words)
		else report_mismatch("word count", exp_words, word_total);
		assert (wr_q.size() == 0 && word_q.size() == 0)
		else report_failure("write commands and data words left unpaired");
		if (n_bursts[0] > 0 && n_bursts[1] > 0 && n_bursts[2] > 0) begin
			assert (first_ports[0] != first_ports[1] && first_ports[1] != first_ports[2] &&
				first_ports[0] != first_ports[2])
			else report_failure("first three commands not from three different ports");
		end
		$display("test %0s: %0d commands, %0d words, %0d errors", test_name, cmd_total,
			word_total, test_errors);
		tests++;
		if (test_errors != 0)
			failed_tests++;
		errors += test_errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int fd;
		int fields;
		string line;
		string name;
		int b0, b1, b2, bp, exp_cmds, exp_words;
		logic [31:0] a0, a1, a2;
		trig_rst_arbiter_2x = 1'b1;
		app_rdy = 1'b1;
		app_wdf_rdy = 1'b1;
		for (int p = 0; p < 3; p++) begin
			addr_rd_data[p] = '0;
			addr_rd_size[p] = '0;
			addr_stage[p] = '0;
			addr_pend[p] = '0;
			n_bursts[p] = 0;
			addr_rd[p] = 0;
		end
		for (int p = 0; p < 2; p++) begin
			data_rd_data[p] = '0;
			data_rd_size[p] = '0;
			beat_stage[p] = '0;
			beat_pend[p] = '0;
			beat_rd[p] = 0;
		end
		lfsr = 16'd29;
		back_pressure = 1'b0;
		in_reset = 1'b1;
		quiet = 1'b0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		fd = $fopen("verif/arbiter_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/arbiter_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip header and blank lines
				if (line.len() < 2 || line[0] == "#")
					continue;
				fields = $sscanf(line, "%s %d %d %d %h %h %h %d %d %d", name, b0, b1, b2,
					a0, a1, a2, bp, exp_cmds, exp_words);
				assert (fields == 10)
				else begin
					$display("malformed line in cases file: %0s", line);
					errors++;
				end
				if (fields == 10) begin
					test_name = name;
					back_pressure = (bp != 0);
					load_clients(b0, b1, b2, app_addr_t'(a0), app_addr_t'(a1), app_addr_t'(a2));
					run_test(exp_cmds, exp_words);
				end
			end
			$fclose(fd);
		end
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0 && tests > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/arbiter_cases.txt
# name bursts_la0 bursts_la1 bursts_rb base_la0 base_la1 base_rb backpressure exp_cmds exp_words
# base addresses are hex, address bits 28:27 carry the port number, bursts at most 8 per port
idle            0 0 0 0000000 8000000 10000000 0  0  0
single_la0      1 0 0 0000100 8000000 10000000 0  1  2
single_la1      0 1 0 0000000 8000200 10000000 0  1  2
readback_only   0 0 1 0000000 8000000 10000300 0  1  0
readback_pair   0 0 2 0000000 8000000 10000500 0  2  0
pods_only       2 3 0 0000600 8000600 10000000 0  5 10
all_ports       3 3 3 0000400 8000400 10000400 0  9 12
all_ports_deep  8 8 8 0001000 8001000 10001000 0 24 32
single_la0_bp   1 0 0 0000700 8000000 10000000 1  1  2
all_ports_bp    3 3 3 0000800 8000800 10000800 1  9 12
deep_bp         8 7 6 0002000 8002000 10002000 1 21 30
uneven_bp       1 8 2 0003000 8003000 10003000 1 11 18

// File: build.f
common/arbiter_pkg.sv
common/mig_app_pkg.sv
source/sync_fifo.sv
arbiter/port_arbiter.sv
arbiter/burst_packer.sv
source/mig_issuer.sv
source/memory_arbiter.sv
verif/memory_arbiter_tb.sv

// File: Makefile
# Verilator build and run of the memory arbiter testbench

VERILATOR ?= verilator
TOP       ?= memory_arbiter_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
